// File: Makefile
TOP = tb_ex_stage

.PHONY: build run clean

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

# Exit status of the simulation binary is the test result
run: build
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: design/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  ex_op_e op_i,
    input  word_t  pc_i,
    input  word_t  src1_i,
    input  word_t  src2_i,
    input  word_t  imm_i,
    output word_t  alu_result_o
);

    shamt_t shamt;
    word_t  sum;
    word_t  diff;
    logic   lt_signed;
    logic   lt_unsigned;

    // Shift amount from the low bits of the second source
    assign shamt = shamt_t'(src2_i);

    assign sum  = src1_i + src2_i;
    assign diff = src1_i - src2_i;

    assign lt_signed   = $signed(src1_i) < $signed(src2_i);
    assign lt_unsigned = src1_i < src2_i;

    always_comb begin
        case (op_i)
            // Arithmetic and compare
            OP_ADD:   alu_result_o = sum;
            OP_SUB:   alu_result_o = diff;
            OP_SLT:   alu_result_o = word_t'(lt_signed);
            OP_SLTU:  alu_result_o = word_t'(lt_unsigned);

            // Logic
            OP_AND:   alu_result_o = src1_i & src2_i;
            OP_OR:    alu_result_o = src1_i | src2_i;
            OP_XOR:   alu_result_o = src1_i ^ src2_i;
            OP_NOR:   alu_result_o = ~(src1_i | src2_i);

            // Shifts
            OP_SLL:   alu_result_o = src1_i << shamt;
            OP_SRL:   alu_result_o = src1_i >> shamt;
            OP_SRA:   alu_result_o = word_t'($signed(src1_i) >>> shamt);

            // Moves, imm already holds the shifted upper bits
            OP_LUI:   alu_result_o = imm_i;
            OP_PCADD: alu_result_o = pc_i + imm_i;

            // Link value for calls
            OP_BL,
            OP_JIRL:  alu_result_o = pc_i + 32'd4;

            default:  alu_result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit
    import ex_pkg::*;
(
    input  ex_op_e op_i,
    input  word_t  pc_i,
    input  word_t  src1_i,
    input  word_t  src2_i,
    input  word_t  imm_i,
    input  word_t  pred_next_pc_i,
    output logic   is_branch_o,
    output word_t  actual_next_pc_o,
    output logic   mispredict_o
);

    logic  taken;
    word_t target;
    word_t fall_through;

    assign fall_through = pc_i + 32'd4;

    // Condition evaluation
    always_comb begin
        taken       = 1'b0;
        is_branch_o = 1'b1;
        case (op_i)
            OP_BEQ:  taken = src1_i == src2_i;
            OP_BNE:  taken = src1_i != src2_i;
            OP_BLT:  taken = $signed(src1_i) < $signed(src2_i);
            OP_BGE:  taken = $signed(src1_i) >= $signed(src2_i);
            OP_BLTU: taken = src1_i < src2_i;
            OP_BGEU: taken = src1_i >= src2_i;
            OP_B,
            OP_BL,
            OP_JIRL: taken = 1'b1;
            default: is_branch_o = 1'b0;
        endcase
    end

    // Register-indirect for JIRL, pc-relative for the rest
    assign target = (op_i == OP_JIRL) ? src1_i + imm_i : pc_i + imm_i;

    assign actual_next_pc_o = taken ? target : fall_through;

    assign mispredict_o = is_branch_o && (actual_next_pc_o != pred_next_pc_i);

endmodule

`default_nettype wire

// File: design/ex_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_div_unit
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  div_kind_e kind_i,
    input  word_t     dividend_i,
    input  word_t     divisor_i,
    output logic      busy_o,
    output logic      done_o,
    output word_t     quotient_o,
    output word_t     remainder_o
);

    localparam int CNT_W = $clog2(`EX_DIV_STEPS + 1);

    div_fsm_e            state_q;
    logic [CNT_W-1:0]    step_q;
    logic                is_signed;
    word_t               divisor_eff;
    word_t               dividend_abs;
    word_t               divisor_abs;
    word_t               rem_q;
    word_t               quo_q;
    word_t               dvs_q;
    logic                neg_quo_q;
    logic                neg_rem_q;
    logic [`EX_XLEN:0]   shifted;
    logic [`EX_XLEN:0]   trial;

    assign is_signed = (kind_i == DIV_S) || (kind_i == MOD_S);

    // Zero divisor behaves as one
    assign divisor_eff  = (divisor_i == '0) ? word_t'(1) : divisor_i;
    assign dividend_abs = (is_signed && dividend_i[`EX_XLEN-1]) ? -dividend_i : dividend_i;
    assign divisor_abs  = (is_signed && divisor_eff[`EX_XLEN-1]) ? -divisor_eff : divisor_eff;

    // Restoring step, borrow out means the divisor did not fit
    assign shifted = {rem_q, quo_q[`EX_XLEN-1]};
    assign trial   = shifted - {1'b0, dvs_q};

    assign busy_o = state_q != DIV_IDLE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= state_q == DIV_FIX;
            case (state_q)
                DIV_IDLE: begin
                    step_q <= '0;
                    if (start_i) state_q <= DIV_RUN;
                end
                DIV_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == CNT_W'(`EX_DIV_STEPS - 1)) state_q <= DIV_FIX;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            DIV_IDLE: if (start_i) begin
                rem_q     <= '0;
                quo_q     <= dividend_abs;
                dvs_q     <= divisor_abs;
                neg_quo_q <= is_signed && (dividend_i[`EX_XLEN-1] ^ divisor_eff[`EX_XLEN-1]);
                neg_rem_q <= is_signed && dividend_i[`EX_XLEN-1];
            end
            DIV_RUN: begin
                rem_q <= trial[`EX_XLEN] ? shifted[`EX_XLEN-1:0] : trial[`EX_XLEN-1:0];
                quo_q <= {quo_q[`EX_XLEN-2:0], ~trial[`EX_XLEN]};
            end
            DIV_FIX: begin
                quotient_o  <= neg_quo_q ? -quo_q : quo_q;
                remainder_o <= neg_rem_q ? -rem_q : rem_q;
            end
            default: ;
        endcase
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start_i |-> !busy_o);

endmodule

`default_nettype wire

// File: design/ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data word and pc width
`define EX_XLEN 32

// Register file index width
`define EX_REG_ADDR_W 5

////////////////////////////////////////////////////////////////////////
// Multi-cycle unit latencies
////////////////////////////////////////////////////////////////////////

// Start pulse to done pulse of the multiplier
`define EX_MUL_LATENCY 2

// One quotient bit per step
`define EX_DIV_STEPS 32

`endif

// File: design/ex_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_mul_unit
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  mul_kind_e kind_i,
    input  word_t     a_i,
    input  word_t     b_i,
    output logic      done_o,
    output word_t     product_o
);

    logic                            s1_valid_q;
    logic                            ext_sign;
    logic signed [`EX_XLEN:0]        a_q;
    logic signed [`EX_XLEN:0]        b_q;
    mul_kind_e                       kind_q;
    logic signed [2*`EX_XLEN+1:0]    full_prod;

    // Only the unsigned high product needs zero extension
    assign ext_sign = kind_i != MUL_HU;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid_q <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            s1_valid_q <= start_i;
            done_o     <= s1_valid_q;
        end
    end

    // Stage one, extended operands
    always_ff @(posedge clk) begin
        if (start_i) begin
            a_q    <= {ext_sign & a_i[`EX_XLEN-1], a_i};
            b_q    <= {ext_sign & b_i[`EX_XLEN-1], b_i};
            kind_q <= kind_i;
        end
    end

    assign full_prod = a_q * b_q;

    // Stage two, word select
    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            product_o <= (kind_q == MUL_LO) ? full_prod[`EX_XLEN-1:0]
                                            : full_prod[2*`EX_XLEN-1:`EX_XLEN];
        end
    end

    a_mul_latency: assert property (@(posedge clk) disable iff (rst)
        start_i |-> ##(`EX_MUL_LATENCY) done_o);

endmodule

`default_nettype wire

// File: design/ex_muldiv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_muldiv_ctrl
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  ex_op_e op_i,
    input  word_t  src1_i,
    input  word_t  src2_i,
    input  logic   advance_i,
    input  logic   flush_i,
    output logic   stall_o,
    output logic   result_ready_o,
    output word_t  result_o
);

    logic      is_mul, is_div;
    mul_kind_e mul_kind;
    div_kind_e div_kind;
    logic      started_q, finished_q, mul_start_q, div_start_q;
    logic [`EX_MUL_LATENCY-1:0] mul_own_q;
    logic      mul_done, div_done, div_busy;
    logic      clear, issue_ok, mul_issue, div_issue, mul_accept, div_accept;
    word_t     product, quotient, remainder;

    always_comb begin
        is_mul = 1'b1;
        is_div = 1'b0;
        mul_kind = MUL_LO;
        div_kind = DIV_S;
        case (op_i)
            OP_MUL:   mul_kind = MUL_LO;
            OP_MULH:  mul_kind = MUL_HS;
            OP_MULHU: mul_kind = MUL_HU;
            OP_DIV:   begin is_mul = 1'b0; is_div = 1'b1; div_kind = DIV_S; end
            OP_DIVU:  begin is_mul = 1'b0; is_div = 1'b1; div_kind = DIV_U; end
            OP_MOD:   begin is_mul = 1'b0; is_div = 1'b1; div_kind = MOD_S; end
            OP_MODU:  begin is_mul = 1'b0; is_div = 1'b1; div_kind = MOD_U; end
            default:  is_mul = 1'b0;
        endcase
    end

    assign clear     = advance_i | flush_i;
    assign issue_ok  = !started_q && !finished_q && !flush_i;
    assign mul_issue = is_mul && issue_ok;
    assign div_issue = is_div && issue_ok && !div_busy;

    // Drop done pulses that belong to a flushed op
    assign mul_accept = is_mul && mul_done && mul_own_q[`EX_MUL_LATENCY-1] && !finished_q;
    assign div_accept = is_div && div_done && started_q && !finished_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            {started_q, finished_q, mul_start_q, div_start_q} <= '0;
            mul_own_q <= '0;
        end else begin
            mul_start_q <= mul_issue;
            div_start_q <= div_issue;
            if (clear) begin
                {started_q, finished_q} <= '0;
                mul_own_q <= '0;
            end else begin
                mul_own_q <= {mul_own_q[`EX_MUL_LATENCY-2:0], mul_start_q};
                if (mul_issue || div_issue) started_q <= 1'b1;
                if (mul_accept || div_accept) finished_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!clear && mul_accept) result_o <= product;
        else if (!clear && div_accept) begin
            result_o <= (div_kind inside {DIV_S, DIV_U}) ? quotient : remainder;
        end
    end

    ex_mul_unit i_mul_unit (.clk(clk), .rst(rst), .start_i(mul_start_q), .kind_i(mul_kind),
        .a_i(src1_i), .b_i(src2_i), .done_o(mul_done), .product_o(product));

    ex_div_unit i_div_unit (.clk(clk), .rst(rst), .start_i(div_start_q), .kind_i(div_kind),
        .dividend_i(src1_i), .divisor_i(src2_i), .busy_o(div_busy), .done_o(div_done),
        .quotient_o(quotient), .remainder_o(remainder));

    assign stall_o        = (is_mul || is_div) && !finished_q;
    assign result_ready_o = finished_q;

endmodule

`default_nettype wire

// File: design/ex_pkg.sv
`default_nettype none

`include "ex_macros.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] word_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [4:0] shamt_t;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA, OP_LUI, OP_PCADD,
        OP_MUL, OP_MULH, OP_MULHU,
        OP_DIV, OP_DIVU, OP_MOD, OP_MODU,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_B, OP_BL, OP_JIRL
    } ex_op_e;

    typedef enum logic [1:0] {MUL_LO, MUL_HS, MUL_HU} mul_kind_e;

    typedef enum logic [1:0] {DIV_S, DIV_U, MOD_S, MOD_U} div_kind_e;

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_FIX} div_fsm_e;

    // Ops that go through the multiplier or divider
    function automatic logic is_muldiv_op(ex_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
    endfunction

endpackage

`default_nettype wire

// File: design/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Issue slot
    input  logic      valid_i,
    input  ex_op_e    op_i,
    input  word_t     pc_i,
    input  word_t     src1_i,
    input  word_t     src2_i,
    input  word_t     imm_i,
    input  reg_addr_t rd_i,
    input  logic      rd_we_i,
    input  word_t     pred_next_pc_i,

    input  logic      advance_i,
    input  logic      flush_i,
    output logic      advance_ready_o,

    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output logic      wb_we_o,
    output word_t     wb_data_o,

    output logic      fwd_we_o,
    output logic      fwd_ready_o,
    output reg_addr_t fwd_rd_o,
    output word_t     fwd_data_o,

    output logic      redirect_o,
    output word_t     redirect_target_o
);

    ex_op_e md_op;
    word_t  alu_result, md_result, ex_result, actual_next_pc;
    logic   is_branch, mispredict, md_stall, md_ready, is_muldiv;

    ex_alu i_alu (.op_i(op_i), .pc_i(pc_i), .src1_i(src1_i), .src2_i(src2_i), .imm_i(imm_i),
        .alu_result_o(alu_result));

    ex_branch_unit i_branch_unit (.op_i(op_i), .pc_i(pc_i), .src1_i(src1_i), .src2_i(src2_i),
        .imm_i(imm_i), .pred_next_pc_i(pred_next_pc_i), .is_branch_o(is_branch),
        .actual_next_pc_o(actual_next_pc), .mispredict_o(mispredict));

    // An empty slot must not start a multi-cycle op
    assign md_op = valid_i ? op_i : OP_ADD;

    ex_muldiv_ctrl i_muldiv_ctrl (.clk(clk), .rst(rst), .op_i(md_op), .src1_i(src1_i),
        .src2_i(src2_i), .advance_i(advance_i), .flush_i(flush_i), .stall_o(md_stall),
        .result_ready_o(md_ready), .result_o(md_result));

    //////////////////////////////////////////////////////////////////////
    // Result select and forwarding
    //////////////////////////////////////////////////////////////////////

    assign is_muldiv = is_muldiv_op(md_op);
    assign ex_result = is_muldiv ? md_result : alu_result;

    assign fwd_we_o    = valid_i && rd_we_i;
    assign fwd_ready_o = !is_muldiv || md_ready;
    assign fwd_rd_o    = rd_i;
    assign fwd_data_o  = ex_result;

    assign advance_ready_o = !md_stall;

    // Redirect only in the cycle the branch leaves the stage
    assign redirect_o        = advance_i && valid_i && is_branch && mispredict;
    assign redirect_target_o = actual_next_pc;

    //////////////////////////////////////////////////////////////////////
    // Write-back register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else if (advance_i) begin
            wb_valid_o <= valid_i;
            wb_we_o    <= valid_i && rd_we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i && !flush_i) begin
            wb_rd_o   <= rd_i;
            wb_data_o <= ex_result;
        end
    end

    a_advance_when_ready: assert property (@(posedge clk) disable iff (rst)
        advance_i |-> advance_ready_o);

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
+incdir+test
design/ex_pkg.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_mul_unit.sv
design/ex_div_unit.sv
design/ex_muldiv_ctrl.sv
design/ex_stage.sv
test/tb_ex_stage.sv

// File: test/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Multiply and divide ops sit in one contiguous block of the enum
function automatic logic is_long_op(ex_op_e op);
    return (op >= OP_MUL) && (op <= OP_MODU);
endfunction

// Branches and jumps close the enum
function automatic logic is_branch_op(ex_op_e op);
    return op >= OP_BEQ;
endfunction

function automatic word_t ref_result(ex_op_e op, word_t pc, word_t a, word_t b, word_t imm);
    logic signed [63:0] prod_s;
    logic [63:0]        prod_u;
    word_t              d;
    word_t              ds;
    prod_s = 64'($signed(a)) * 64'($signed(b));
    prod_u = {32'd0, a} * {32'd0, b};
    // Zero divisor counts as one
    d = (b == 32'd0) ? 32'd1 : b;
    // Most negative over minus one gives the same result as over one
    ds = (a == MOST_NEG && d == 32'hffff_ffff) ? 32'd1 : d;
    case (op)
        OP_ADD:   return a + b;
        OP_SUB:   return a - b;
        OP_SLT:   return {31'd0, $signed(a) < $signed(b)};
        OP_SLTU:  return {31'd0, a < b};
        OP_AND:   return a & b;
        OP_OR:    return a | b;
        OP_XOR:   return a ^ b;
        OP_NOR:   return ~(a | b);
        OP_SLL:   return a << b[4:0];
        OP_SRL:   return a >> b[4:0];
        OP_SRA:   return word_t'($signed(a) >>> b[4:0]);
        OP_LUI:   return imm;
        OP_PCADD: return pc + imm;
        OP_BL,
        OP_JIRL:  return pc + 32'd4;
        OP_MUL:   return prod_u[31:0];
        OP_MULH:  return prod_s[63:32];
        OP_MULHU: return prod_u[63:32];
        OP_DIV:   return word_t'($signed(a) / $signed(ds));
        OP_DIVU:  return a / d;
        OP_MOD:   return word_t'($signed(a) % $signed(ds));
        OP_MODU:  return a % d;
        default:  return 32'd0;
    endcase
endfunction

function automatic word_t ref_next_pc(ex_op_e op, word_t pc, word_t a, word_t b, word_t imm);
    logic taken;
    case (op)
        OP_BEQ:  taken = a == b;
        OP_BNE:  taken = a != b;
        OP_BLT:  taken = $signed(a) < $signed(b);
        OP_BGE:  taken = $signed(a) >= $signed(b);
        OP_BLTU: taken = a < b;
        OP_BGEU: taken = a >= b;
        OP_B,
        OP_BL,
        OP_JIRL: taken = 1'b1;
        default: taken = 1'b0;
    endcase
    if (!taken) return pc + 32'd4;
    return (op == OP_JIRL) ? a + imm : pc + imm;
endfunction

function automatic logic ref_redirect(ex_op_e op, word_t next_pc, word_t pred);
    return is_branch_op(op) && (next_pc != pred);
endfunction

`endif

// File: test/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int    NUM_INSTR   = 400;
    localparam int    CLK_PERIOD  = 40;
    localparam int    MAX_WAIT    = 120;
    localparam int    WATCHDOG_NS = NUM_INSTR * 40 * CLK_PERIOD;
    localparam word_t MOST_NEG    = {1'b1, {(`EX_XLEN-1){1'b0}}};

    logic      clk;
    logic      rst;
    logic      valid_i;
    ex_op_e    op_i;
    word_t     pc_i, src1_i, src2_i, imm_i, pred_next_pc_i;
    reg_addr_t rd_i;
    logic      rd_we_i, advance_i, flush_i;
    logic      advance_ready_o, wb_valid_o, wb_we_o, fwd_we_o, fwd_ready_o, redirect_o;
    reg_addr_t wb_rd_o, fwd_rd_o;
    word_t     wb_data_o, fwd_data_o, redirect_target_o;

    // Current instruction and its expected results
    logic      cur_long;
    logic      cur_we;
    reg_addr_t cur_rd;
    word_t     exp_data;
    word_t     exp_next_pc;
    logic      exp_redirect;

    logic      wb_loaded;
    logic      wb_flushed;
    int        num_issued;
    int        num_checked;
    word_t     exp_data_q[$];
    reg_addr_t exp_rd_q[$];
    logic      exp_we_q[$];

    `include "ex_ref_model.svh"

    ex_stage i_ex_stage (.clk(clk), .rst(rst), .valid_i(valid_i), .op_i(op_i), .pc_i(pc_i),
        .src1_i(src1_i), .src2_i(src2_i), .imm_i(imm_i), .rd_i(rd_i), .rd_we_i(rd_we_i),
        .pred_next_pc_i(pred_next_pc_i), .advance_i(advance_i), .flush_i(flush_i),
        .advance_ready_o(advance_ready_o), .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o),
        .wb_we_o(wb_we_o), .wb_data_o(wb_data_o), .fwd_we_o(fwd_we_o),
        .fwd_ready_o(fwd_ready_o), .fwd_rd_o(fwd_rd_o), .fwd_data_o(fwd_data_o),
        .redirect_o(redirect_o), .redirect_target_o(redirect_target_o));

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // Corner values show up often
    function automatic word_t pick_operand();
        case ($urandom_range(7, 0))
            0: return 32'd0;
            1: return MOST_NEG;
            2: return 32'hffff_ffff;
            3: return 32'd1;
            default: return $urandom;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic build_instruction(input logic long_only);
        ex_op_e op;
        word_t  a;
        word_t  b;
        word_t  pc;
        word_t  imm;
        if (long_only) op = ex_op_e'($urandom_range(32'(OP_MODU), 32'(OP_MUL)));
        else op = ex_op_e'($urandom_range(32'(OP_JIRL), 0));
        a = pick_operand();
        b = pick_operand();
        if (op >= OP_DIV && op <= OP_MODU) begin
            case ($urandom_range(3, 0))
                0: b = 32'd0;
                1: begin
                    a = MOST_NEG;
                    b = 32'hffff_ffff;
                end
                default: ;
            endcase
        end
        pc  = $urandom & 32'hffff_fffc;
        imm = $urandom;
        cur_long    = is_long_op(op);
        cur_rd      = reg_addr_t'($urandom_range(31, 0));
        cur_we      = $urandom_range(3, 0) != 0;
        exp_data    = ref_result(op, pc, a, b, imm);
        exp_next_pc = ref_next_pc(op, pc, a, b, imm);
        // Half the time a correct prediction
        pred_next_pc_i = ($urandom_range(1, 0) == 0) ? exp_next_pc : $urandom;
        exp_redirect   = ref_redirect(op, exp_next_pc, pred_next_pc_i);
        valid_i = 1'b1;
        op_i    = op;
        pc_i    = pc;
        src1_i  = a;
        src2_i  = b;
        imm_i   = imm;
        rd_i    = cur_rd;
        rd_we_i = cur_we;
    endtask

    // Waits for advance_ready_o, then advances or flushes the slot
    task automatic issue_instruction(input logic do_flush);
        int   waited;
        logic first;
        logic done;
        waited = 0;
        first  = 1'b1;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            check_value("redirect_o", word_t'(redirect_o), 32'd0);
            check_value("fwd_we_o", word_t'(fwd_we_o), word_t'(cur_we));
            check_value("fwd_rd_o", word_t'(fwd_rd_o), word_t'(cur_rd));
            if (!cur_long || first) begin
                check_value("advance_ready_o", word_t'(advance_ready_o), word_t'(!cur_long));
            end
            if (advance_ready_o) begin
                check_value("fwd_ready_o", word_t'(fwd_ready_o), 32'd1);
                check_value("fwd_data_o", fwd_data_o, exp_data);
            end else begin
                check_value("fwd_ready_o", word_t'(fwd_ready_o), 32'd0);
            end
            if (do_flush) begin
                flush_i = 1'b1;
                done    = 1'b1;
            end else if (advance_ready_o) begin
                advance_i = 1'b1;
                exp_data_q.push_back(exp_data);
                exp_rd_q.push_back(cur_rd);
                exp_we_q.push_back(cur_we);
                num_issued++;
                done = 1'b1;
            end else if (waited == MAX_WAIT) begin
                fail_run("advance_ready_o stayed low too long for a mul/div op");
            end
            waited++;
            first = 1'b0;
        end
    endtask

    // Redirect is sampled while advance_i is still high
    task automatic check_redirect();
        if (advance_i) begin
            check_value("redirect_o", word_t'(redirect_o), word_t'(exp_redirect));
            if (exp_redirect) check_value("redirect_target_o", redirect_target_o, exp_next_pc);
        end
    endtask

    initial begin
        int   n;
        logic do_flush;
        logic long_only;
        void'($urandom(32'h629f_a5a9));
        clk            = 1'b0;
        rst            = 1'b1;
        valid_i        = 1'b0;
        op_i           = OP_ADD;
        pc_i           = '0;
        src1_i         = '0;
        src2_i         = '0;
        imm_i          = '0;
        rd_i           = '0;
        rd_we_i        = 1'b0;
        pred_next_pc_i = '0;
        advance_i      = 1'b0;
        flush_i        = 1'b0;
        num_issued     = 0;
        num_checked    = 0;
        long_only      = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("wb_valid_o", word_t'(wb_valid_o), 32'd0);
        check_value("wb_we_o", word_t'(wb_we_o), 32'd0);
        check_value("redirect_o", word_t'(redirect_o), 32'd0);
        check_value("advance_ready_o", word_t'(advance_ready_o), 32'd1);
        for (n = 0; n < NUM_INSTR; n++) begin
            build_instruction(long_only);
            do_flush = $urandom_range(9, 0) == 0;
            issue_instruction(do_flush);
            @(negedge clk);
            check_redirect();
            advance_i = 1'b0;
            flush_i   = 1'b0;
            // A mul/div op follows every flush
            long_only = do_flush;
        end
        valid_i = 1'b0;
        repeat (3) @(negedge clk);
        if (exp_data_q.size() != 0 || num_checked != num_issued) begin
            fail_run("not every advanced instruction reached the write-back register");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write-back compare
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            wb_loaded  <= 1'b0;
            wb_flushed <= 1'b0;
        end else begin
            wb_loaded  <= advance_i && !flush_i;
            wb_flushed <= flush_i;
        end
    end

    always @(negedge clk) begin
        if (wb_flushed) begin
            check_value("wb_valid_o", word_t'(wb_valid_o), 32'd0);
        end else if (wb_loaded) begin
            if (exp_data_q.size() == 0) begin
                fail_run("write-back register loaded with no instruction outstanding");
            end else begin
                check_value("wb_valid_o", word_t'(wb_valid_o), 32'd1);
                check_value("wb_we_o", word_t'(wb_we_o), word_t'(exp_we_q.pop_front()));
                check_value("wb_rd_o", word_t'(wb_rd_o), word_t'(exp_rd_q.pop_front()));
                check_value("wb_data_o", wb_data_o, exp_data_q.pop_front());
                num_checked++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all instructions completed");
    end

endmodule

`default_nettype wire
